// ==== Bender.yml ====
package:
  name: la32_core

sources:
  - include_dirs:
      - design
    files:
      - design/core_pkg.sv
      - design/inst_fetch.sv
      - design/inst_decode.sv
      - design/reg_bypass.sv
      - design/reg_file.sv
      - design/execute.sv
      - design/core.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_clock_gen.sv
      - tb/core_assert.sv
      - tb/tb_core.sv

// ==== design/core.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module core (
    input  logic                   clock,
    input  logic                   reset,
    output logic                   iram_rd_en,
    output logic [`ADDR_WIDTH-1:0] iram_rd_addr,
    input  logic [`DATA_WIDTH-1:0] iram_rd_data,
    input  logic                   iram_rd_valid,
    output logic [`ADDR_WIDTH-1:0] debug0_wb_pc,
    output logic [3:0]             debug0_wb_rf_wen,
    output logic [`REG_WIDTH-1:0]  debug0_wb_rf_wnum,
    output logic [`DATA_WIDTH-1:0] debug0_wb_rf_wdata
);

    import core_pkg::*;

    logic                   redirect;
    logic [`ADDR_WIDTH-1:0] redirect_pc;
    logic                   fetch_valid;
    logic [`ADDR_WIDTH-1:0] fetch_pc;

    logic [`REG_WIDTH-1:0]  rs1_addr;
    logic [`REG_WIDTH-1:0]  rs2_addr;
    logic [`DATA_WIDTH-1:0] rs1_data;
    logic [`DATA_WIDTH-1:0] rs2_data;
    logic [`DATA_WIDTH-1:0] rf1_data;
    logic [`DATA_WIDTH-1:0] rf2_data;

    id_ex_t id_ex;
    wb_t    ex_fwd;
    wb_t    wb;

    inst_fetch u_fetch (
        .clock         (clock),
        .reset         (reset),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .iram_rd_en    (iram_rd_en),
        .iram_rd_addr  (iram_rd_addr),
        .iram_rd_valid (iram_rd_valid),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc)
    );

    inst_decode u_decode (
        .clock        (clock),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_pc     (fetch_pc),
        .iram_rd_data (iram_rd_data),
        .rs1_addr     (rs1_addr),
        .rs1_data     (rs1_data),
        .rs2_addr     (rs2_addr),
        .rs2_data     (rs2_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .id_ex        (id_ex)
    );

    // one bypass per source operand
    reg_bypass u_bypass1 (
        .req_addr (rs1_addr),
        .ex_fwd   (ex_fwd),
        .wb       (wb),
        .rf_data  (rf1_data),
        .req_data (rs1_data)
    );

    reg_bypass u_bypass2 (
        .req_addr (rs2_addr),
        .ex_fwd   (ex_fwd),
        .wb       (wb),
        .rf_data  (rf2_data),
        .req_data (rs2_data)
    );

    reg_file u_reg_file (
        .clock   (clock),
        .reset   (reset),
        .r1_addr (rs1_addr),
        .r1_data (rf1_data),
        .r2_addr (rs2_addr),
        .r2_data (rf2_data),
        .wb      (wb)
    );

    execute u_execute (
        .clock  (clock),
        .reset  (reset),
        .id_ex  (id_ex),
        .ex_fwd (ex_fwd),
        .wb     (wb)
    );

    // commits to r0 are not reported
    assign debug0_wb_rf_wen   = (wb.valid && wb.rw_en && wb.rw_addr != '0) ? 4'hf : 4'h0;
    assign debug0_wb_pc       = wb.pc;
    assign debug0_wb_rf_wnum  = wb.rw_addr;
    assign debug0_wb_rf_wdata = wb.rw_data;

endmodule

// ==== design/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// pc and fetch address width
`define ADDR_WIDTH 32

// integer datapath width
`define DATA_WIDTH 32

// register number width for 32 architectural registers
`define REG_WIDTH 5

// first fetch address after reset
`define RESET_PC 32'h1c000000

`endif

// ==== design/core_pkg.sv ====
`include "core_defines.svh"

package core_pkg;

    // instruction word decoded by format
    typedef struct packed {
        logic [16:0]            opcode;
        logic [`REG_WIDTH-1:0] rk;
        logic [`REG_WIDTH-1:0] rj;
        logic [`REG_WIDTH-1:0] rd;
    } fmt_3r_t;

    typedef struct packed {
        logic [9:0]             opcode;
        logic [11:0]            si12;
        logic [`REG_WIDTH-1:0] rj;
        logic [`REG_WIDTH-1:0] rd;
    } fmt_2ri12_t;

    typedef struct packed {
        logic [6:0]             opcode;
        logic [19:0]            si20;
        logic [`REG_WIDTH-1:0] rd;
    } fmt_1ri20_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [15:0]            offs16;
        logic [`REG_WIDTH-1:0] rj;
        logic [`REG_WIDTH-1:0] rd;
    } fmt_2ri16_t;

    typedef union packed {
        logic [31:0] raw;
        fmt_3r_t     fmt_3r;
        fmt_2ri12_t  fmt_2ri12;
        fmt_1ri20_t  fmt_1ri20;
        fmt_2ri16_t  fmt_2ri16;
    } inst_word_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_t;

    // 3r opcodes in bits 31:15
    localparam logic [16:0] opc_add_w = 17'h00020;
    localparam logic [16:0] opc_sub_w = 17'h00022;
    localparam logic [16:0] opc_slt   = 17'h00024;
    localparam logic [16:0] opc_and   = 17'h00029;
    localparam logic [16:0] opc_or    = 17'h0002a;
    localparam logic [16:0] opc_xor   = 17'h0002b;

    // 2ri12 opcodes in bits 31:22
    localparam logic [9:0] opc_addi_w = 10'h00a;
    localparam logic [9:0] opc_andi   = 10'h00d;
    localparam logic [9:0] opc_ori    = 10'h00e;

    localparam logic [6:0] opc_lu12i_w = 7'h0a;

    // branch opcodes in bits 31:26
    localparam logic [5:0] opc_beq = 6'h16;
    localparam logic [5:0] opc_bne = 6'h17;

    typedef struct packed {
        logic                   valid;
        logic [`ADDR_WIDTH-1:0] pc;
        alu_op_t                alu_op;
        logic [`DATA_WIDTH-1:0] opnd_a;
        logic [`DATA_WIDTH-1:0] opnd_b;
        logic                   rw_en;
        logic [`REG_WIDTH-1:0]  rw_addr;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`ADDR_WIDTH-1:0] pc;
        logic                   rw_en;
        logic [`REG_WIDTH-1:0]  rw_addr;
        logic [`DATA_WIDTH-1:0] rw_data;
    } wb_t;

endpackage

// ==== design/execute.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module execute (
    input  logic             clock,
    input  logic             reset,
    input  core_pkg::id_ex_t id_ex,
    output core_pkg::wb_t    ex_fwd,
    output core_pkg::wb_t    wb
);

    import core_pkg::*;

    logic [`DATA_WIDTH-1:0] result;
    logic                   less;

    assign less = $signed(id_ex.opnd_a) < $signed(id_ex.opnd_b);

    always_comb begin
        case (id_ex.alu_op)
            alu_add: result = id_ex.opnd_a + id_ex.opnd_b;
            alu_sub: result = id_ex.opnd_a - id_ex.opnd_b;
            alu_and: result = id_ex.opnd_a & id_ex.opnd_b;
            alu_or:  result = id_ex.opnd_a | id_ex.opnd_b;
            alu_xor: result = id_ex.opnd_a ^ id_ex.opnd_b;
            alu_slt: result = {{(`DATA_WIDTH-1){1'b0}}, less};
            // upper immediate already shifted in decode
            alu_lui: result = id_ex.opnd_b;
            default: result = id_ex.opnd_a + id_ex.opnd_b;
        endcase
    end

    // result seen by the bypass this cycle
    always_comb begin
        ex_fwd.valid   = id_ex.valid;
        ex_fwd.pc      = id_ex.pc;
        ex_fwd.rw_en   = id_ex.rw_en;
        ex_fwd.rw_addr = id_ex.rw_addr;
        ex_fwd.rw_data = result;
    end

    always_ff @(posedge clock) begin
        wb <= ex_fwd;
        if (reset) begin
            wb.valid <= 1'b0;
        end
    end

endmodule

// ==== design/inst_decode.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module inst_decode (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   fetch_valid,
    input  logic [`ADDR_WIDTH-1:0] fetch_pc,
    input  logic [`DATA_WIDTH-1:0] iram_rd_data,
    output logic [`REG_WIDTH-1:0]  rs1_addr,
    input  logic [`DATA_WIDTH-1:0] rs1_data,
    output logic [`REG_WIDTH-1:0]  rs2_addr,
    input  logic [`DATA_WIDTH-1:0] rs2_data,
    output logic                   redirect,
    output logic [`ADDR_WIDTH-1:0] redirect_pc,
    output core_pkg::id_ex_t       id_ex
);

    import core_pkg::*;

    inst_word_t inst;
    id_ex_t     id_next;
    logic       is_beq;
    logic       is_bne;
    logic       src_equal;

    assign inst = iram_rd_data;

    assign is_beq = inst.fmt_2ri16.opcode == opc_beq;
    assign is_bne = inst.fmt_2ri16.opcode == opc_bne;

    // branches compare rj against rd
    assign rs1_addr = inst.fmt_3r.rj;
    assign rs2_addr = (is_beq || is_bne) ? inst.fmt_2ri16.rd : inst.fmt_3r.rk;

    assign src_equal = rs1_data == rs2_data;
    assign redirect  = fetch_valid & ((is_beq & src_equal) | (is_bne & ~src_equal));
    assign redirect_pc = fetch_pc
                       + {{(`ADDR_WIDTH-18){inst.fmt_2ri16.offs16[15]}},
                          inst.fmt_2ri16.offs16, 2'b00};

    always_comb begin
        id_next.valid   = fetch_valid;
        id_next.pc      = fetch_pc;
        id_next.alu_op  = alu_add;
        id_next.opnd_a  = rs1_data;
        id_next.opnd_b  = rs2_data;
        id_next.rw_en   = 1'b0;
        id_next.rw_addr = inst.fmt_3r.rd;

        case (inst.fmt_3r.opcode)
            opc_add_w: begin
                id_next.alu_op = alu_add;
                id_next.rw_en  = 1'b1;
            end
            opc_sub_w: begin
                id_next.alu_op = alu_sub;
                id_next.rw_en  = 1'b1;
            end
            opc_slt: begin
                id_next.alu_op = alu_slt;
                id_next.rw_en  = 1'b1;
            end
            opc_and: begin
                id_next.alu_op = alu_and;
                id_next.rw_en  = 1'b1;
            end
            opc_or: begin
                id_next.alu_op = alu_or;
                id_next.rw_en  = 1'b1;
            end
            opc_xor: begin
                id_next.alu_op = alu_xor;
                id_next.rw_en  = 1'b1;
            end
            default: ;
        endcase

        // addi sign-extends while the logical ops zero-extend
        case (inst.fmt_2ri12.opcode)
            opc_addi_w: begin
                id_next.alu_op = alu_add;
                id_next.opnd_b = {{(`DATA_WIDTH-12){inst.fmt_2ri12.si12[11]}},
                                  inst.fmt_2ri12.si12};
                id_next.rw_en  = 1'b1;
            end
            opc_andi: begin
                id_next.alu_op = alu_and;
                id_next.opnd_b = {{(`DATA_WIDTH-12){1'b0}}, inst.fmt_2ri12.si12};
                id_next.rw_en  = 1'b1;
            end
            opc_ori: begin
                id_next.alu_op = alu_or;
                id_next.opnd_b = {{(`DATA_WIDTH-12){1'b0}}, inst.fmt_2ri12.si12};
                id_next.rw_en  = 1'b1;
            end
            default: ;
        endcase

        if (inst.fmt_1ri20.opcode == opc_lu12i_w) begin
            id_next.alu_op = alu_lui;
            id_next.opnd_b = {inst.fmt_1ri20.si20, 12'h000};
            id_next.rw_en  = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        id_ex <= id_next;
        if (reset) begin
            id_ex.valid <= 1'b0;
        end
    end

endmodule

// ==== design/inst_fetch.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module inst_fetch (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   redirect,
    input  logic [`ADDR_WIDTH-1:0] redirect_pc,
    output logic                   iram_rd_en,
    output logic [`ADDR_WIDTH-1:0] iram_rd_addr,
    input  logic                   iram_rd_valid,
    output logic                   fetch_valid,
    output logic [`ADDR_WIDTH-1:0] fetch_pc
);

    logic                   fetch_en;
    logic                   squash;
    logic [`ADDR_WIDTH-1:0] pc;

    // fetching starts on the first cycle out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_en <= 1'b0;
            squash   <= 1'b0;
            pc       <= `RESET_PC;
        end else begin
            fetch_en <= 1'b1;
            // word issued alongside the redirect is wrong path
            squash   <= redirect;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (fetch_en) begin
                pc <= pc + `ADDR_WIDTH'd4;
            end
        end
    end

    // pc of the word coming back next cycle
    always_ff @(posedge clock) begin
        if (fetch_en) begin
            fetch_pc <= pc;
        end
    end

    assign iram_rd_en   = fetch_en;
    assign iram_rd_addr = pc;
    assign fetch_valid  = iram_rd_valid & ~squash;

endmodule

// ==== design/reg_bypass.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module reg_bypass (
    input  logic [`REG_WIDTH-1:0]  req_addr,
    input  core_pkg::wb_t          ex_fwd,
    input  core_pkg::wb_t          wb,
    input  logic [`DATA_WIDTH-1:0] rf_data,
    output logic [`DATA_WIDTH-1:0] req_data
);

    logic ex_hit;
    logic wb_hit;

    // r0 never forwards
    assign ex_hit = ex_fwd.valid && ex_fwd.rw_en && ex_fwd.rw_addr == req_addr
                    && req_addr != '0;
    assign wb_hit = wb.valid && wb.rw_en && wb.rw_addr == req_addr
                    && req_addr != '0;

    // youngest producer wins
    always_comb begin
        if (ex_hit) begin
            req_data = ex_fwd.rw_data;
        end else if (wb_hit) begin
            req_data = wb.rw_data;
        end else begin
            req_data = rf_data;
        end
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module reg_file (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`REG_WIDTH-1:0]  r1_addr,
    output logic [`DATA_WIDTH-1:0] r1_data,
    input  logic [`REG_WIDTH-1:0]  r2_addr,
    output logic [`DATA_WIDTH-1:0] r2_data,
    input  core_pkg::wb_t          wb
);

    logic [`DATA_WIDTH-1:0] regs [2**`REG_WIDTH];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**`REG_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rw_en && wb.rw_addr != '0) begin
            regs[wb.rw_addr] <= wb.rw_data;
        end
    end

    // r0 is never written so it reads zero
    assign r1_data = regs[r1_addr];
    assign r2_data = regs[r2_addr];

endmodule

// ==== filelist.f ====
+incdir+design
design/core_pkg.sv
design/inst_fetch.sv
design/inst_decode.sv
design/reg_bypass.sv
design/reg_file.sv
design/execute.sv
design/core.sv
tb/tb_clock_gen.sv
tb/core_assert.sv
tb/tb_core.sv

// ==== tb/core_assert.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module core_assert (
    input logic                   clock,
    input logic                   reset,
    input logic                   iram_rd_en,
    input logic [`ADDR_WIDTH-1:0] iram_rd_addr,
    input logic [3:0]             debug0_wb_rf_wen,
    input logic [`REG_WIDTH-1:0]  debug0_wb_rf_wnum
);

    logic protocol_error = 1'b0;

    // no fetch while held in reset
    a_no_fetch_in_reset: assert property (@(posedge clock)
        reset |-> iram_rd_en !== 1'b1)
    else begin
        $error("iram_rd_en high during reset");
        protocol_error = 1'b1;
    end

    a_fetch_aligned: assert property (@(posedge clock) disable iff (reset)
        iram_rd_en |-> iram_rd_addr[1:0] == 2'b00)
    else begin
        $error("iram_rd_addr not word aligned");
        protocol_error = 1'b1;
    end

    // byte enables are all or nothing
    a_wen_legal: assert property (@(posedge clock) disable iff (reset)
        debug0_wb_rf_wen == 4'h0 || debug0_wb_rf_wen == 4'hf)
    else begin
        $error("debug0_wb_rf_wen is neither 0 nor 4'hf");
        protocol_error = 1'b1;
    end

    a_no_r0_commit: assert property (@(posedge clock) disable iff (reset)
        debug0_wb_rf_wen != 4'h0 |-> debug0_wb_rf_wnum != '0)
    else begin
        $error("commit reported for r0");
        protocol_error = 1'b1;
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam real half_period   = 2.0;
    localparam int  reset_cycles  = 2;

    initial begin
        clock = 1'b0;
        forever begin
            #half_period clock = ~clock;
        end
    end

    // released just after the second rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

// ==== tb/tb_core.sv ====
`timescale 1ns/10ps
`include "core_defines.svh"

module tb_core;

    import core_pkg::*;

    localparam int prog_len        = 200;
    localparam int loop_idx        = prog_len - 1;
    localparam int mem_words       = 256;
    localparam int clock_period_ns = 4;
    localparam int watchdog_ns     = (prog_len * 3 + 50) * clock_period_ns;
    localparam logic [31:0] loop_pc = `RESET_PC + 32'(loop_idx * 4);
    localparam logic [31:0] mem_end = `RESET_PC + 32'(mem_words * 4);

    typedef enum logic [3:0] {
        k_add, k_sub, k_and, k_or, k_xor, k_slt,
        k_addi, k_andi, k_ori, k_lui, k_beq, k_bne
    } kind_t;

    typedef struct packed {
        kind_t       kind;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [19:0] imm;
    } slot_t;

    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] pc;
        logic [`REG_WIDTH-1:0]  wnum;
        logic [`DATA_WIDTH-1:0] wdata;
    } commit_t;

    logic                   clock;
    logic                   reset;
    logic                   iram_rd_en;
    logic [`ADDR_WIDTH-1:0] iram_rd_addr;
    logic [`DATA_WIDTH-1:0] iram_rd_data;
    logic                   iram_rd_valid;
    logic [`ADDR_WIDTH-1:0] debug0_wb_pc;
    logic [3:0]             debug0_wb_rf_wen;
    logic [`REG_WIDTH-1:0]  debug0_wb_rf_wnum;
    logic [`DATA_WIDTH-1:0] debug0_wb_rf_wdata;

    logic [31:0] mem [mem_words];
    slot_t       prog [prog_len];
    commit_t     exp_q [$];
    commit_t     exp_head;
    logic        exp_avail;
    logic        commit_seen;
    logic        req_en;
    logic [31:0] req_addr;
    logic [7:0]  req_idx;
    logic [31:0] lfsr_state;
    int          loop_fetches;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    core u_dut (
        .clock              (clock),
        .reset              (reset),
        .iram_rd_en         (iram_rd_en),
        .iram_rd_addr       (iram_rd_addr),
        .iram_rd_data       (iram_rd_data),
        .iram_rd_valid      (iram_rd_valid),
        .debug0_wb_pc       (debug0_wb_pc),
        .debug0_wb_rf_wen   (debug0_wb_rf_wen),
        .debug0_wb_rf_wnum  (debug0_wb_rf_wnum),
        .debug0_wb_rf_wdata (debug0_wb_rf_wdata)
    );

    bind core core_assert u_core_assert (
        .clock             (clock),
        .reset             (reset),
        .iram_rd_en        (iram_rd_en),
        .iram_rd_addr      (iram_rd_addr),
        .debug0_wb_rf_wen  (debug0_wb_rf_wen),
        .debug0_wb_rf_wnum (debug0_wb_rf_wnum)
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] enc_3r(logic [16:0] opcode, logic [4:0] rk,
                                           logic [4:0] rj, logic [4:0] rd);
        inst_word_t w;
        w.fmt_3r.opcode = opcode;
        w.fmt_3r.rk     = rk;
        w.fmt_3r.rj     = rj;
        w.fmt_3r.rd     = rd;
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_2ri12(logic [9:0] opcode, logic [11:0] si12,
                                              logic [4:0] rj, logic [4:0] rd);
        inst_word_t w;
        w.fmt_2ri12.opcode = opcode;
        w.fmt_2ri12.si12   = si12;
        w.fmt_2ri12.rj     = rj;
        w.fmt_2ri12.rd     = rd;
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_1ri20(logic [6:0] opcode, logic [19:0] si20,
                                              logic [4:0] rd);
        inst_word_t w;
        w.fmt_1ri20.opcode = opcode;
        w.fmt_1ri20.si20   = si20;
        w.fmt_1ri20.rd     = rd;
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_2ri16(logic [5:0] opcode, logic [15:0] offs16,
                                              logic [4:0] rj, logic [4:0] rd);
        inst_word_t w;
        w.fmt_2ri16.opcode = opcode;
        w.fmt_2ri16.offs16 = offs16;
        w.fmt_2ri16.rj     = rj;
        w.fmt_2ri16.rd     = rd;
        return w.raw;
    endfunction

    function automatic logic [31:0] encode_slot(slot_t s);
        case (s.kind)
            k_add:   return enc_3r(opc_add_w, s.rk, s.rj, s.rd);
            k_sub:   return enc_3r(opc_sub_w, s.rk, s.rj, s.rd);
            k_and:   return enc_3r(opc_and, s.rk, s.rj, s.rd);
            k_or:    return enc_3r(opc_or, s.rk, s.rj, s.rd);
            k_xor:   return enc_3r(opc_xor, s.rk, s.rj, s.rd);
            k_slt:   return enc_3r(opc_slt, s.rk, s.rj, s.rd);
            k_addi:  return enc_2ri12(opc_addi_w, s.imm[11:0], s.rj, s.rd);
            k_andi:  return enc_2ri12(opc_andi, s.imm[11:0], s.rj, s.rd);
            k_ori:   return enc_2ri12(opc_ori, s.imm[11:0], s.rj, s.rd);
            k_lui:   return enc_1ri20(opc_lu12i_w, s.imm, s.rd);
            k_beq:   return enc_2ri16(opc_beq, s.imm[15:0], s.rj, s.rd);
            default: return enc_2ri16(opc_bne, s.imm[15:0], s.rj, s.rd);
        endcase
    endfunction

    task automatic build_program();
        slot_t s;
        // unused words are ori r0, r0, index
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = enc_2ri12(opc_ori, 12'(i), 5'd0, 5'd0);
        end
        for (int i = 0; i < loop_idx; i++) begin
            s.rd = 5'(rand_bits(3));
            s.rj = 5'(rand_bits(3));
            s.rk = 5'(rand_bits(3));
            if (i % 8 == 7) begin
                s.kind = rand_bits(1) == 32'd1 ? k_bne : k_beq;
                // skip one to three instructions
                s.imm  = 20'(2 + rand_bits(2) % 3);
            end else begin
                s.kind = kind_t'(4'(rand_bits(4) % 10));
                s.imm  = 20'(rand_bits(20));
            end
            prog[i] = s;
        end
        // final self loop beq r0, r0, 0
        s = '{kind: k_beq, rd: 5'd0, rj: 5'd0, rk: 5'd0, imm: 20'd0};
        prog[loop_idx] = s;
        for (int i = 0; i < prog_len; i++) begin
            mem[i] = encode_slot(prog[i]);
        end
    endtask

    function automatic logic [31:0] alu_model(slot_t s, logic [31:0] a, logic [31:0] b);
        logic [31:0] imm_s;
        logic [31:0] imm_z;
        imm_s = {{20{s.imm[11]}}, s.imm[11:0]};
        imm_z = {20'h00000, s.imm[11:0]};
        case (s.kind)
            k_add:   return a + b;
            k_sub:   return a - b;
            k_and:   return a & b;
            k_or:    return a | b;
            k_xor:   return a ^ b;
            k_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            k_addi:  return a + imm_s;
            k_andi:  return a & imm_z;
            k_ori:   return a | imm_z;
            default: return {s.imm, 12'h000};
        endcase
    endfunction

    // in-order execution queueing one entry per nonzero register write
    task automatic run_reference();
        logic [31:0] regs [32];
        slot_t       s;
        commit_t     c;
        logic        taken;
        int          idx;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        idx = 0;
        while (idx != loop_idx) begin
            s = prog[idx];
            if (s.kind == k_beq || s.kind == k_bne) begin
                taken = (regs[s.rj] == regs[s.rd]) == (s.kind == k_beq);
                idx   = taken ? idx + int'($signed(s.imm[15:0])) : idx + 1;
            end else begin
                if (s.rd != 5'd0) begin
                    regs[s.rd] = alu_model(s, regs[s.rj], regs[s.rk]);
                    c.pc       = `RESET_PC + 32'(idx * 4);
                    c.wnum     = s.rd;
                    c.wdata    = regs[s.rd];
                    exp_q.push_back(c);
                end
                idx++;
            end
        end
    endtask

    task automatic refresh_head();
        if (exp_q.size() > 0) begin
            exp_head  = exp_q[0];
            exp_avail = 1'b1;
        end else begin
            exp_avail = 1'b0;
        end
    endtask

    // mid-cycle sampling of the core outputs
    always @(negedge clock) begin
        req_en      = iram_rd_en === 1'b1;
        req_addr    = iram_rd_addr;
        commit_seen = debug0_wb_rf_wen === 4'hf;
        if (req_en && req_addr == loop_pc) begin
            loop_fetches++;
        end
        if (u_dut.u_core_assert.protocol_error) begin
            stop_on_error("a bound protocol assertion on the core failed");
        end
    end

    // memory answer and queue advance 1 ns after the edge
    always @(posedge clock) begin
        #1;
        if (commit_seen && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
        iram_rd_valid = req_en;
        if (req_en) begin
            if (req_addr < `RESET_PC || req_addr >= mem_end || req_addr[1:0] != 2'b00) begin
                stop_on_error("instruction fetch outside the program memory");
            end else begin
                req_idx      = 8'((req_addr - `RESET_PC) >> 2);
                iram_rd_data = mem[req_idx];
            end
        end
    end

    a_first_fetch: assert property (@(posedge clock) disable iff (reset)
        $rose(iram_rd_en) |-> iram_rd_addr == `RESET_PC)
        else stop_on_error($sformatf("FAILED iram_rd_addr expected %h got %h",
                                     `RESET_PC, $sampled(iram_rd_addr)));

    a_commit_expected: assert property (@(posedge clock) disable iff (reset)
        debug0_wb_rf_wen == 4'hf |-> exp_avail)
        else stop_on_error("a register commit appeared that the reference model did not expect");

    a_commit_pc: assert property (@(posedge clock) disable iff (reset)
        debug0_wb_rf_wen == 4'hf && exp_avail |-> debug0_wb_pc == exp_head.pc)
        else stop_on_error($sformatf("FAILED debug0_wb_pc expected %h got %h",
                                     $sampled(exp_head.pc), $sampled(debug0_wb_pc)));

    a_commit_wnum: assert property (@(posedge clock) disable iff (reset)
        debug0_wb_rf_wen == 4'hf && exp_avail |-> debug0_wb_rf_wnum == exp_head.wnum)
        else stop_on_error($sformatf("FAILED debug0_wb_rf_wnum expected %h got %h",
                                     $sampled(exp_head.wnum), $sampled(debug0_wb_rf_wnum)));

    a_commit_wdata: assert property (@(posedge clock) disable iff (reset)
        debug0_wb_rf_wen == 4'hf && exp_avail |-> debug0_wb_rf_wdata == exp_head.wdata)
        else stop_on_error($sformatf("FAILED debug0_wb_rf_wdata expected %h got %h",
                                     $sampled(exp_head.wdata), $sampled(debug0_wb_rf_wdata)));

    initial begin
        iram_rd_valid = 1'b0;
        iram_rd_data  = '0;
        req_en        = 1'b0;
        req_addr      = '0;
        req_idx       = '0;
        commit_seen   = 1'b0;
        loop_fetches  = 0;
        lfsr_state    = 32'hb3a2;
        build_program();
        run_reference();
        refresh_head();
        // done once every commit is seen and the core spins on the loop
        while (loop_fetches < 3 || exp_q.size() != 0) begin
            @(negedge clock);
        end
        @(negedge clock);
        if (u_dut.u_core_assert.protocol_error) begin
            stop_on_error("a bound protocol assertion on the core failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

    initial begin
        #(watchdog_ns);
        stop_on_error("timeout, the program never reached its final loop");
    end

endmodule
